// File: Makefile
TOP = sdram_subsys_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sdram_subsys.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: hw/sdram_addr_path.sv
module sdram_addr_path (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              latch,
    input  sdram_cmd_pkg::phase_e             phase,
    input  sdram_host_pkg::host_req_t         req_data,
    input  logic                              capture,
    input  logic [sdram_cmd_pkg::DQ_BITS-1:0] rd_dq,
    output sdram_cmd_pkg::sdram_pins_t        pins,
    output logic [sdram_cmd_pkg::DQ_BITS-1:0] wr_dq,
    output logic                              wr_oe,
    output logic [sdram_cmd_pkg::DQ_BITS-1:0] rd_data,
    output logic                              rd_valid
);

    localparam int COL = sdram_cmd_pkg::COL_BITS;
    localparam int ROW = sdram_cmd_pkg::ROW_BITS;
    localparam int BANK = sdram_cmd_pkg::BANK_BITS;

    sdram_host_pkg::host_req_t  req_q;
    sdram_cmd_pkg::sdram_pins_t pins_d;
    logic                       wr_oe_d;

    always_ff @(posedge clk) begin
        if (latch) begin
            req_q <= req_data;
        end
    end

    // activate comes in the accept cycle, so it reads the live request.
    always_comb begin
        pins_d = '{cmd: sdram_cmd_pkg::NOP, ba: '0, addr: '0};
        wr_oe_d = 1'b0;
        case (phase)
            sdram_cmd_pkg::PH_ACT: begin
                pins_d.cmd = sdram_cmd_pkg::ACTIVATE;
                pins_d.ba = req_data.addr[COL+ROW +: BANK];
                pins_d.addr = req_data.addr[COL +: ROW];
            end
            sdram_cmd_pkg::PH_COL: begin
                pins_d.ba = req_q.addr[COL+ROW +: BANK];
                pins_d.addr = ROW'(req_q.addr[COL-1:0]);
                if (req_q.op == sdram_host_pkg::OP_WRITE) begin
                    pins_d.cmd = sdram_cmd_pkg::WRITE;
                    wr_oe_d = 1'b1;
                end else begin
                    pins_d.cmd = sdram_cmd_pkg::READ;
                end
            end
            sdram_cmd_pkg::PH_STOP: pins_d.cmd = sdram_cmd_pkg::BURST_STOP;
            sdram_cmd_pkg::PH_PRE:  pins_d.cmd = sdram_cmd_pkg::PRECHARGE;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pins <= '{cmd: sdram_cmd_pkg::NOP, ba: '0, addr: '0};
            wr_oe <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            pins <= pins_d;
            wr_oe <= wr_oe_d;
            rd_valid <= capture;
        end
    end

    always_ff @(posedge clk) begin
        if (phase == sdram_cmd_pkg::PH_COL) begin
            wr_dq <= req_q.wdata;
        end
        if (capture) begin
            rd_data <= rd_dq;
        end
    end

endmodule

// File: hw/sdram_bank_model.sv
module sdram_bank_model #(
    parameter int burst_max = 64,
    parameter int mem_addr_width = 16
) (
    input  logic                              clk,
    input  logic                              rst,
    input  sdram_cmd_pkg::sdram_pins_t        pins,
    input  logic [sdram_cmd_pkg::DQ_BITS-1:0] dq_in,
    output logic [sdram_cmd_pkg::DQ_BITS-1:0] rd_dq,
    output logic                              rd_oe
);

    localparam int COL = sdram_cmd_pkg::COL_BITS;
    localparam int OPEN_BITS = sdram_cmd_pkg::BANK_BITS + sdram_cmd_pkg::ROW_BITS;
    localparam int ADDR_BITS = OPEN_BITS + COL;
    localparam int CNT_W = $clog2(burst_max + 2);

    typedef enum logic [1:0] {
        IDLE,
        ACTIVATED,
        WRITE,
        READ
    } state_e;

    state_e                            state;
    sdram_cmd_pkg::cmd_e               cmd;
    logic [OPEN_BITS-1:0]              open_row;
    logic [COL-1:0]                    col_q;
    logic [CNT_W-1:0]                  cnt;
    logic [ADDR_BITS-1:0]              wr_addr;
    logic [ADDR_BITS-1:0]              rd_addr;
    logic                              burst_end;
    logic [sdram_cmd_pkg::DQ_BITS-1:0] mem [2**mem_addr_width];

    assign cmd = pins.cmd;
    assign wr_addr = {open_row, pins.addr[COL-1:0]};

    // word cnt-1 of the burst; the carry runs from column into row.
    assign rd_addr = {open_row, col_q} + ADDR_BITS'(cnt) - ADDR_BITS'(1);

    // cnt of 2 or more means a word is already out.
    assign burst_end = ((cnt >= CNT_W'(2)) && (cmd == sdram_cmd_pkg::BURST_STOP))
                     || (cnt == CNT_W'(burst_max + 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            cnt <= '0;
            rd_oe <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd == sdram_cmd_pkg::ACTIVATE) begin
                        state <= ACTIVATED;
                    end
                end
                ACTIVATED: begin
                    if (cmd == sdram_cmd_pkg::WRITE) begin
                        state <= WRITE;
                    end else if (cmd == sdram_cmd_pkg::READ) begin
                        state <= READ;
                        cnt <= CNT_W'(1);
                    end
                end
                WRITE: begin
                    state <= IDLE;
                end
                READ: begin
                    if (burst_end) begin
                        state <= IDLE;
                        cnt <= '0;
                        rd_oe <= 1'b0;
                    end else begin
                        cnt <= cnt + 1'b1;
                        rd_oe <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // open row and start column.
    always_ff @(posedge clk) begin
        if (state == IDLE && cmd == sdram_cmd_pkg::ACTIVATE) begin
            open_row <= {pins.ba, pins.addr};
        end
        if (state == ACTIVATED && cmd == sdram_cmd_pkg::READ) begin
            col_q <= pins.addr[COL-1:0];
        end
    end

    // storage aliases above mem_addr_width.
    always_ff @(posedge clk) begin
        if (state == ACTIVATED && cmd == sdram_cmd_pkg::WRITE) begin
            mem[wr_addr[mem_addr_width-1:0]] <= dq_in;
        end
        if (state == READ && !burst_end) begin
            rd_dq <= mem[rd_addr[mem_addr_width-1:0]];
        end
    end

endmodule

// File: hw/sdram_burst_timer.sv
module sdram_burst_timer #(
    parameter int burst_max = 64
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                start,
    input  logic [sdram_host_pkg::LEN_BITS-1:0] len,
    output logic                                capture,
    output logic                                last_issue,
    output logic                                last_capture
);

    // cycle of the first read word, counted from the start edge.
    localparam int READ_LAT = 4;
    localparam int CYC_W = sdram_host_pkg::LEN_BITS + 1;

    logic             active;
    logic [CYC_W-1:0] cyc;
    logic [CYC_W-1:0] len_eff;
    logic [CYC_W-1:0] issue_end;
    logic [CYC_W-1:0] cap_end;

    assign len_eff = (len == '0 || len > burst_max) ? CYC_W'(burst_max) : CYC_W'(len);

    always_ff @(posedge clk) begin
        if (start) begin
            issue_end <= len_eff + CYC_W'(READ_LAT - 2);
            cap_end <= len_eff + CYC_W'(READ_LAT - 1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            cyc <= '0;
        end else if (start) begin
            active <= 1'b1;
            cyc <= CYC_W'(1);
        end else if (active) begin
            cyc <= cyc + 1'b1;
            if (last_capture) begin
                active <= 1'b0;
            end
        end
    end

    assign last_issue = active && (cyc == issue_end);
    assign capture = active && (cyc >= CYC_W'(READ_LAT)) && (cyc <= cap_end);
    assign last_capture = active && (cyc == cap_end);

endmodule

// File: hw/sdram_cmd_pkg.sv
package sdram_cmd_pkg;

    localparam int BANK_BITS = 2;
    localparam int ROW_BITS = 13;
    localparam int COL_BITS = 10;
    localparam int DQ_BITS = 16;

    // command word is {ras_n, cas_n, we_n}.
    typedef enum logic [2:0] {
        MRS        = 3'b000,
        REFRESH    = 3'b001,
        PRECHARGE  = 3'b010,
        ACTIVATE   = 3'b011,
        WRITE      = 3'b100,
        READ       = 3'b101,
        BURST_STOP = 3'b110,
        NOP        = 3'b111
    } cmd_e;

    // which pin word the controller drives next cycle.
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_ACT,
        PH_COL,
        PH_STOP,
        PH_PRE
    } phase_e;

    typedef struct packed {
        cmd_e                 cmd;
        logic [BANK_BITS-1:0] ba;
        logic [ROW_BITS-1:0]  addr;
    } sdram_pins_t;

endpackage

// File: hw/sdram_ctrl_fsm.sv
module sdram_ctrl_fsm #(
    parameter int burst_max = 64
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req,
    input  sdram_host_pkg::host_op_e req_op,
    input  logic                     last_issue,
    input  logic                     last_capture,
    output logic                     latch,
    output sdram_cmd_pkg::phase_e    phase,
    output logic                     start,
    output logic                     busy,
    output logic                     done
);

    typedef enum logic [2:0] {
        IDLE,
        ACT,
        WR,
        RD,
        RD_WAIT,
        PRE
    } state_e;

    // guard against a read that never reports its last word.
    localparam int WAIT_LIMIT = burst_max + 2;
    localparam int WAIT_W = $clog2(WAIT_LIMIT + 1);

    state_e                   state;
    state_e                   state_next;
    sdram_host_pkg::host_op_e op_q;
    logic [WAIT_W-1:0]        wait_cnt;
    logic                     wait_expired;

    assign latch = (state == IDLE) && req;
    assign start = latch && (req_op == sdram_host_pkg::OP_READ);
    assign busy = (state != IDLE);
    assign done = (state == PRE);
    assign wait_expired = (wait_cnt == WAIT_W'(WAIT_LIMIT));

    always_comb begin
        state_next = state;
        phase = sdram_cmd_pkg::PH_IDLE;
        case (state)
            IDLE: begin
                if (req) begin
                    state_next = ACT;
                    phase = sdram_cmd_pkg::PH_ACT;
                end
            end
            ACT: begin
                phase = sdram_cmd_pkg::PH_COL;
                if (op_q == sdram_host_pkg::OP_WRITE) begin
                    state_next = WR;
                end else begin
                    state_next = RD;
                end
            end
            WR: begin
                state_next = PRE;
                phase = sdram_cmd_pkg::PH_PRE;
            end
            RD: begin
                state_next = RD_WAIT;
            end
            RD_WAIT: begin
                if (last_issue) begin
                    phase = sdram_cmd_pkg::PH_STOP;
                end else if (last_capture || wait_expired) begin
                    state_next = PRE;
                    phase = sdram_cmd_pkg::PH_PRE;
                end
            end
            PRE: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (latch) begin
            op_q <= req_op;
        end
    end

    // cycles spent waiting for read data.
    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt <= '0;
        end else if (state == RD_WAIT) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

endmodule

// File: hw/sdram_host_pkg.sv
package sdram_host_pkg;

    // word address is bank:row:column.
    localparam int ADDR_BITS = sdram_cmd_pkg::BANK_BITS
                             + sdram_cmd_pkg::ROW_BITS
                             + sdram_cmd_pkg::COL_BITS;
    localparam int LEN_BITS = 7;

    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } host_op_e;

    // len is the read burst length, 1 to 64.
    typedef struct packed {
        host_op_e                          op;
        logic [ADDR_BITS-1:0]              addr;
        logic [sdram_cmd_pkg::DQ_BITS-1:0] wdata;
        logic [LEN_BITS-1:0]               len;
    } host_req_t;

endpackage

// File: hw/sdram_subsys_top.sv
module sdram_subsys_top #(
    parameter int burst_max = 64,
    parameter int mem_addr_width = 16
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              req,
    input  sdram_host_pkg::host_req_t         req_data,
    output logic                              busy,
    output logic                              done,
    output logic [sdram_cmd_pkg::DQ_BITS-1:0] rd_data,
    output logic                              rd_valid,
    output sdram_cmd_pkg::sdram_pins_t        pins
);

    logic                              latch;
    logic                              start;
    logic                              capture;
    logic                              last_issue;
    logic                              last_capture;
    sdram_cmd_pkg::phase_e             phase;
    logic [sdram_cmd_pkg::DQ_BITS-1:0] wr_dq;
    logic [sdram_cmd_pkg::DQ_BITS-1:0] rd_dq;
    logic [sdram_cmd_pkg::DQ_BITS-1:0] dq_bus;
    logic                              wr_oe;
    logic                              rd_oe;

    // controller drive wins on the resolved dq bus.
    assign dq_bus = wr_oe ? wr_dq : (rd_oe ? rd_dq : '0);

    sdram_ctrl_fsm #(
        .burst_max(burst_max)
    ) sdram_ctrl_fsm_inst (
        .clk(clk),
        .rst(rst),
        .req(req),
        .req_op(req_data.op),
        .last_issue(last_issue),
        .last_capture(last_capture),
        .latch(latch),
        .phase(phase),
        .start(start),
        .busy(busy),
        .done(done)
    );

    sdram_burst_timer #(
        .burst_max(burst_max)
    ) sdram_burst_timer_inst (
        .clk(clk),
        .rst(rst),
        .start(start),
        .len(req_data.len),
        .capture(capture),
        .last_issue(last_issue),
        .last_capture(last_capture)
    );

    sdram_addr_path sdram_addr_path_inst (
        .clk(clk),
        .rst(rst),
        .latch(latch),
        .phase(phase),
        .req_data(req_data),
        .capture(capture),
        .rd_dq(dq_bus),
        .pins(pins),
        .wr_dq(wr_dq),
        .wr_oe(wr_oe),
        .rd_data(rd_data),
        .rd_valid(rd_valid)
    );

    sdram_bank_model #(
        .burst_max(burst_max),
        .mem_addr_width(mem_addr_width)
    ) sdram_bank_model_inst (
        .clk(clk),
        .rst(rst),
        .pins(pins),
        .dq_in(dq_bus),
        .rd_dq(rd_dq),
        .rd_oe(rd_oe)
    );

endmodule

// File: sdram_subsys.f
hw/sdram_cmd_pkg.sv
hw/sdram_host_pkg.sv
hw/sdram_ctrl_fsm.sv
hw/sdram_burst_timer.sv
hw/sdram_addr_path.sv
hw/sdram_bank_model.sv
hw/sdram_subsys_top.sv
testbench/sdram_subsys_properties.sv
testbench/sdram_subsys_tb.sv

// File: testbench/sdram_subsys_properties.sv
module sdram_ctrl_properties (
    input logic                  clk,
    input logic                  rst,
    input logic                  latch,
    input sdram_cmd_pkg::phase_e phase,
    input logic                  busy,
    input logic                  done
);

    timeunit 1ns;
    timeprecision 1ps;

    done_single_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done stayed high for more than one cycle");

    accept_sets_busy: assert property (@(posedge clk) disable iff (rst) latch |=> busy)
        else $error("busy did not rise after an accepted request");

    // busy may only drop once done has pulsed.
    busy_until_done: assert property (@(posedge clk) disable iff (rst)
        (busy && !done) |=> busy)
        else $error("busy dropped before done");

    col_after_act: assert property (@(posedge clk) disable iff (rst)
        (phase == sdram_cmd_pkg::PH_COL) |-> ($past(phase) == sdram_cmd_pkg::PH_ACT))
        else $error("column phase without a preceding activate phase");

endmodule

bind sdram_ctrl_fsm sdram_ctrl_properties sdram_ctrl_properties_inst (
    .clk(clk),
    .rst(rst),
    .latch(latch),
    .phase(phase),
    .busy(busy),
    .done(done)
);

// File: testbench/sdram_subsys_tb.sv
module sdram_subsys_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int BURST_MAX = 64;
    localparam int MEM_ADDR_WIDTH = 16;
    localparam int SEQ_WORDS = 96;
    // worst-case cycles per request including the req pulse.
    localparam int WRITE_CYC = 8;
    localparam int READ_CYC = BURST_MAX + 10;
    localparam int CYCLE_LIMIT = 16 + 120 * WRITE_CYC + 20 * READ_CYC + 100;

    logic                       clk;
    logic                       rst;
    logic                       req;
    sdram_host_pkg::host_req_t  req_data;
    logic                       busy;
    logic                       done;
    logic [15:0]                rd_data;
    logic                       rd_valid;
    sdram_cmd_pkg::sdram_pins_t pins;

    logic [15:0] ref_mem [2**MEM_ADDR_WIDTH];
    logic [15:0] rd_q [$];
    logic [31:0] rng;
    logic        valid_at_done;
    int          words_at_done;
    int          error_count;
    int          done_count;
    int          word_total;
    int          cycle_count = 0;

    sdram_subsys_top #(
        .burst_max(BURST_MAX),
        .mem_addr_width(MEM_ADDR_WIDTH)
    ) sdram_subsys_top_inst (
        .clk(clk),
        .rst(rst),
        .req(req),
        .req_data(req_data),
        .busy(busy),
        .done(done),
        .rd_data(rd_data),
        .rd_valid(rd_valid),
        .pins(pins)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // collects read words and done pulses mid-cycle.
    always @(negedge clk) begin
        if (!rst) begin
            if (rd_valid) begin
                rd_q.push_back(rd_data);
            end
            if (done) begin
                done_count++;
                valid_at_done = rd_valid;
                words_at_done = rd_q.size();
            end
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic sdram_host_pkg::host_req_t make_req(
        input sdram_host_pkg::host_op_e op,
        input logic [24:0]              addr,
        input logic [15:0]              wdata,
        input logic [6:0]               len
    );
        sdram_host_pkg::host_req_t r;
        r.op = op;
        r.addr = addr;
        r.wdata = wdata;
        r.len = len;
        return r;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
        error_count++;
    endtask

    task automatic send_req(input sdram_host_pkg::host_req_t r);
        @(posedge clk);
        req <= 1'b1;
        req_data <= r;
        @(posedge clk);
        req <= 1'b0;
    endtask

    task automatic wait_done(input int n0, input int limit);
        int waited;
        waited = 0;
        while (done_count == n0 && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        if (done_count == n0) begin
            $display("request got no done pulse within %0d cycles", limit);
            error_count++;
        end
    endtask

    task automatic check_burst(input logic [24:0] start, input int len);
        int          k;
        logic [24:0] a;
        logic [15:0] exp;
        if (words_at_done != len || !valid_at_done) begin
            $display("done came with %0d of %0d words and rd_valid %0b",
                     words_at_done, len, valid_at_done);
            error_count++;
        end
        if (rd_q.size() != len) begin
            $display("read burst at 0x%h returned %0d words instead of %0d",
                     start, rd_q.size(), len);
            error_count++;
        end
        for (k = 0; k < rd_q.size() && k < len; k++) begin
            a = start + 25'(k);
            exp = ref_mem[a[MEM_ADDR_WIDTH-1:0]];
            if (rd_q[k] !== exp) begin
                report_mismatch("rd_data", rd_q[k], exp);
            end
        end
        word_total += rd_q.size();
    endtask

    task automatic write_word(input logic [24:0] addr, input logic [15:0] data);
        int n0;
        n0 = done_count;
        send_req(make_req(sdram_host_pkg::OP_WRITE, addr, data, 7'd1));
        wait_done(n0, WRITE_CYC);
        ref_mem[addr[MEM_ADDR_WIDTH-1:0]] = data;
    endtask

    task automatic read_burst(input logic [24:0] start, input int len);
        int n0;
        n0 = done_count;
        rd_q.delete();
        send_req(make_req(sdram_host_pkg::OP_READ, start, 16'h0, 7'(len)));
        wait_done(n0, READ_CYC);
        repeat (3) @(posedge clk);
        check_burst(start, len);
    endtask

    // second req lands gap+1 cycles after the accepted one.
    task automatic ignore_req_while_busy(input sdram_host_pkg::host_req_t main_req,
                                         input sdram_host_pkg::host_req_t extra_req,
                                         input int gap);
        int n0;
        n0 = done_count;
        rd_q.delete();
        send_req(main_req);
        repeat (gap) @(posedge clk);
        req <= 1'b1;
        req_data <= extra_req;
        @(negedge clk);
        if (busy !== 1'b1) begin
            report_mismatch("busy", busy, 32'h1);
        end
        @(posedge clk);
        req <= 1'b0;
        wait_done(n0, READ_CYC);
        repeat (12) @(posedge clk);
        if (done_count != n0 + 1) begin
            $display("request made while busy gave %0d done pulses instead of 1",
                     done_count - n0);
            error_count++;
        end
        if (main_req.op == sdram_host_pkg::OP_WRITE) begin
            ref_mem[main_req.addr[MEM_ADDR_WIDTH-1:0]] = main_req.wdata;
        end else begin
            check_burst(main_req.addr, int'(main_req.len));
        end
    endtask

    initial begin
        logic [24:0] base;
        logic [24:0] addr;
        logic [24:0] bank_addr [4];
        logic [9:0]  col;
        int          len;
        int          offset;
        clk = 1'b0;
        rst = 1'b1;
        req = 1'b0;
        req_data = '0;
        rng = 32'h409a;
        error_count = 0;
        done_count = 0;
        word_total = 0;
        words_at_done = 0;
        valid_at_done = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        if (busy !== 1'b0) begin
            report_mismatch("busy", busy, 32'h0);
        end
        if (done !== 1'b0) begin
            report_mismatch("done", done, 32'h0);
        end
        if (rd_valid !== 1'b0) begin
            report_mismatch("rd_valid", rd_valid, 32'h0);
        end
        if (pins.cmd !== sdram_cmd_pkg::NOP) begin
            report_mismatch("pins.cmd", pins.cmd, sdram_cmd_pkg::NOP);
        end

        rng = xorshift32(rng);
        addr = rng[24:0];
        rng = xorshift32(rng);
        write_word(addr, rng[15:0]);
        read_burst(addr, 1);

        rng = xorshift32(rng);
        base = rng[24:0];
        for (int i = 0; i < SEQ_WORDS; i++) begin
            rng = xorshift32(rng);
            write_word(base + 25'(i), rng[15:0]);
        end
        read_burst(base, BURST_MAX);
        repeat (6) begin
            rng = xorshift32(rng);
            len = int'(rng[5:0]) + 1;
            rng = xorshift32(rng);
            offset = int'(rng[15:0]) % (SEQ_WORDS - len + 1);
            read_burst(base + 25'(offset), len);
        end

        // same column, distinct banks and low row bits.
        rng = xorshift32(rng);
        col = rng[9:0];
        for (int b = 0; b < 4; b++) begin
            rng = xorshift32(rng);
            bank_addr[b] = {2'(b), rng[12:6], 6'(b * 9 + 5), col};
            write_word(bank_addr[b], rng[31:16]);
        end
        for (int b = 0; b < 4; b++) begin
            read_burst(bank_addr[b], 1);
        end

        // burst runs from column 1019 into the next row.
        rng = xorshift32(rng);
        base = {rng[16:2], 10'd1019};
        for (int i = 0; i < 10; i++) begin
            rng = xorshift32(rng);
            write_word(base + 25'(i), rng[15:0]);
        end
        read_burst(base, 10);

        rng = xorshift32(rng);
        addr = rng[24:0];
        write_word(addr + 25'h40, rng[31:16]);
        rng = xorshift32(rng);
        ignore_req_while_busy(make_req(sdram_host_pkg::OP_WRITE, addr, rng[15:0], 7'd1),
                              make_req(sdram_host_pkg::OP_WRITE, addr + 25'h40,
                                       rng[31:16], 7'd1), 1);
        read_burst(addr, 1);
        read_burst(addr + 25'h40, 1);
        rng = xorshift32(rng);
        ignore_req_while_busy(make_req(sdram_host_pkg::OP_READ, base, 16'h0, 7'd8),
                              make_req(sdram_host_pkg::OP_WRITE, addr + 25'h40,
                                       rng[15:0], 7'd1), 4);
        read_burst(addr + 25'h40, 1);

        $display("requests: %0d, words read: %0d, errors: %0d",
                 done_count, word_total, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
